//--- Makefile
TOP = mc_alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

# The run passes only if the pass message shows up in the simulator output
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+10 | tee /dev/stderr | \
		grep -q -F '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

//--- verification/mc_alu_checker.sv
`timescale 1ns/1ps

module mc_alu_checker #(
	parameter int ALU_LATENCY = 8
)
(
	input logic                      clk,
	input logic                      rst_i,
	input logic                      valid_i,
	input mc_alu_pkg::instruction_t  ir_i,
	input mc_alu_pkg::double_value_t a_i,
	input mc_alu_pkg::double_value_t b_i,
	input mc_alu_pkg::double_value_t imm_i,
	input mc_alu_pkg::tid_t          tid_i,
	input mc_alu_pkg::double_value_t res_i,
	input logic                      done_i,
	input mc_alu_pkg::tid_t          res_tid_i
);
	import mc_alu_pkg::*;

	// =========================================================================
	// Reference model
	// =========================================================================

	// Result class of an instruction word, read from the opcode outward
	function automatic alu_sel_e decode_sel(input instruction_t ir);
		if (ir.ri.opcode == OP_MULI)
			return SEL_MUL;
		if (ir.r2.opcode != OP_R2)
			return SEL_NONE;
		if (ir.r2.func == OP_MUL)
			return SEL_MUL;
		if (ir.r2.func != OP_R1)
			return SEL_NONE;
		case (ir.r2.rb)
			OP_I2F:     return SEL_I2F;
			OP_F2I:     return SEL_F2I;
			OP_FTRUNC:  return SEL_TRUNC;
			OP_MCMPRSS: return SEL_CMPRSS;
			default:    return SEL_NONE;
		endcase
	endfunction

	// Rounding toward zero in real arithmetic
	function automatic real trunc_real(input real r);
		return (r < 0.0) ? $ceil(r) : $floor(r);
	endfunction

	function automatic double_value_t expected_result(input instruction_t ir,
		input double_value_t a, input double_value_t b, input double_value_t imm);
		double_value_t mask;
		logic [10:0]   e;
		e    = a[62:52];
		mask = '0;
		case (decode_sel(ir))
			SEL_MUL:
			begin
				// The immediate form multiplies by imm, the register form by b
				if (ir.ri.opcode == OP_MULI)
					return a * imm;
				return a * b;
			end
			SEL_I2F:
				return $realtobits($itor($signed(a)));
			SEL_F2I:
			begin
				// Magnitudes from 2^63 up, NaN and infinity clamp by sign
				if (e >= 11'd1086)
					return a[63] ? 64'h8000_0000_0000_0000 : 64'h7FFF_FFFF_FFFF_FFFF;
				return longint'(trunc_real($bitstoreal(a)));
			end
			SEL_TRUNC:
			begin
				if (e == 11'h7FF)
					return a;
				// Below one the result is a zero that keeps the sign
				if (e < 11'd1023)
					return {a[63], 63'd0};
				return $realtobits(trunc_real($bitstoreal(a)));
			end
			SEL_CMPRSS:
			begin
				for (int n = 0; n < $countones(a); n++)
					mask[n] = 1'b1;
				return mask;
			end
			default:
				return '0;
		endcase
	endfunction

	// =========================================================================
	// Expected result queue
	// =========================================================================

	// Never more than ALU_LATENCY entries are in flight, so 64 slots suffice
	double_value_t exp_val [64];
	tid_t          exp_tid [64];
	logic [5:0]    wr_ptr;
	logic [5:0]    rd_ptr;
	int            age;
	logic          armed;
	double_value_t head_val;
	tid_t          head_tid;
	logic          fail_seen = 1'b0;

	always @(posedge clk)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			age    <= 0;
		end
		else
		begin
			// Cycles since reset, saturating once a full latency has passed
			if (age < ALU_LATENCY)
				age <= age + 1;
			if (valid_i)
			begin
				exp_val[wr_ptr] <= expected_result(ir_i, a_i, b_i, imm_i);
				exp_tid[wr_ptr] <= tid_i;
				wr_ptr          <= wr_ptr + 1'b1;
			end
			if (done_i)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign armed    = age >= ALU_LATENCY;
	assign head_val = exp_val[rd_ptr];
	assign head_tid = exp_tid[rd_ptr];

	// =========================================================================
	// Assertions
	// =========================================================================

	// No strobe can appear until a first issue has crossed the whole pipe
	a_quiet: assert property (@(posedge clk) disable iff (rst_i) !armed |-> !done_i)
	else
	begin
		fail_seen = 1'b1;
		$error("error at %0t: done strobe before any issue could finish", $time);
	end

	// done follows valid by exactly the latency, in both directions
	a_latency: assert property (@(posedge clk) disable iff (rst_i)
		armed |-> done_i == $past(valid_i, ALU_LATENCY))
	else
	begin
		fail_seen = 1'b1;
		$error("error at %0t: done strobe not %0d cycles after valid", $time, ALU_LATENCY);
	end

	a_result: assert property (@(posedge clk) disable iff (rst_i) done_i |-> res_i == head_val)
	else
	begin
		fail_seen = 1'b1;
		$error("error at %0t: result %h, expected %h", $time, $sampled(res_i),
			$sampled(head_val));
	end

	a_tag: assert property (@(posedge clk) disable iff (rst_i) done_i |-> res_tid_i == head_tid)
	else
	begin
		fail_seen = 1'b1;
		$error("error at %0t: tag %0d, expected %0d", $time, $sampled(res_tid_i),
			$sampled(head_tid));
	end

endmodule

// Every instance of the unit gets its own checker
bind mc_alu64 mc_alu_checker #(.ALU_LATENCY(ALU_LATENCY)) u_chk
(
	.clk       (clk),
	.rst_i     (rst_i),
	.valid_i   (valid_i),
	.ir_i      (ir_i),
	.a_i       (a_i),
	.b_i       (b_i),
	.imm_i     (imm_i),
	.tid_i     (tid_i),
	.res_i     (o_o),
	.done_i    (done_o),
	.res_tid_i (tid_o)
);

//--- verification/mc_alu_tb.sv
`timescale 1ns/1ps

module mc_alu_tb;
	import mc_alu_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int LATENCY      = 8;
	localparam int RESET_CYCLES = 4;
	localparam int SETTLE       = 12;
	localparam int GAP          = 6;
	localparam int N_MUL        = 40;
	localparam int N_I2F        = 24;
	localparam int N_FP         = 40;
	localparam int N_CMP        = 16;
	localparam int N_MIX        = 48;
	// Directed operands plus the three unknown instruction words
	localparam int N_EDGE       = 6 + 2 * 8 + 3 + 3;
	localparam int N_ISSUE      = N_MUL + N_I2F + N_FP + N_CMP + N_MIX + N_EDGE;
	localparam int RUN_CYCLES   = RESET_CYCLES + SETTLE + 4 * GAP + N_ISSUE + LATENCY + 4;

	localparam r1_e SUBS [4] = '{OP_I2F, OP_F2I, OP_FTRUNC, OP_MCMPRSS};

	// Zero, one, minus one, plus and minus 2^53, and 2^53 - 1
	localparam double_value_t I2F_EDGES [6] = '{64'd0, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF,
		64'h0020_0000_0000_0000, 64'hFFE0_0000_0000_0000, 64'h001F_FFFF_FFFF_FFFF};

	// Infinity, NaN, -1.5, -0.25, plus and minus 2^63, exponent 62, a denormal
	localparam double_value_t FP_EDGES [8] = '{64'h7FF0_0000_0000_0000,
		64'h7FF8_0000_0000_0001, 64'hBFF8_0000_0000_0000, 64'hBFD0_0000_0000_0000,
		64'h43E0_0000_0000_0000, 64'hC3E0_0000_0000_0000, 64'h43D0_0000_0000_0001,
		64'h0000_0000_0000_0001};

	localparam double_value_t CMP_EDGES [3] = '{64'd0, 64'hFFFF_FFFF_FFFF_FFFF,
		64'h8000_0000_0000_0001};

	logic          clk;
	logic          rst_i;
	logic          valid_i;
	instruction_t  ir_i;
	double_value_t a_i;
	double_value_t b_i;
	double_value_t imm_i;
	tid_t          tid_i;
	double_value_t o_o;
	logic          done_o;
	tid_t          tid_o;
	integer        seed;

	mc_alu64 #(.ALU_LATENCY(LATENCY)) u_dut
	(
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.ir_i    (ir_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.imm_i   (imm_i),
		.tid_i   (tid_i),
		.o_o     (o_o),
		.done_o  (done_o),
		.tid_o   (tid_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// The bound checker raises this flag when one of its assertions fails
	always @(posedge u_dut.u_chk.fail_seen)
	begin
		$display("error at %0t ns: a result check in the bound checker failed", $time);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failed check");
	end

	// Watchdog sized from the scheduled cycles with some slack
	initial
	begin
		#((RUN_CYCLES + 20) * CLK_PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("*** TEST FAILED ***");
		$fatal(1, "Watchdog timeout");
	end

	// =========================================================================
	// Stimulus helpers
	// =========================================================================

	function automatic double_value_t wide_random();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic double_value_t operand_for(input int kind);
		double_value_t r;
		int            pick;
		r    = wide_random();
		pick = {$random(seed)} % 80;
		case (kind)
			// Within 2^53 every integer has an exact double
			2:       return {{11{r[52]}}, r[52:0]};
			// Unbiased exponents from -8 to 71 cover fractions and saturation
			3, 4:    return {r[63], 11'(1015 + pick), r[51:0]};
			default: return r;
		endcase
	endfunction

	// Kinds 0 to 5 are MUL, MULI, I2F, F2I, FTRUNC and MCMPRSS, 6 to 8 are unknown
	task automatic issue_op(input int kind, input double_value_t a);
		instruction_t ir;
		// Register and spare fields stay random, decode must ignore them
		ir = $random(seed);
		case (kind)
			0:
			begin
				ir.r2.opcode = OP_R2;
				ir.r2.func   = OP_MUL;
			end
			1:
				ir.ri.opcode = OP_MULI;
			2, 3, 4, 5:
			begin
				ir.r2.opcode = OP_R2;
				ir.r2.func   = OP_R1;
				ir.r2.rb     = SUBS[kind - 2];
			end
			6:
				ir.r2.opcode = opcode_e'(6'h3F);
			7:
			begin
				ir.r2.opcode = OP_R2;
				ir.r2.func   = func_e'(6'h2A);
			end
			default:
			begin
				ir.r2.opcode = OP_R2;
				ir.r2.func   = OP_R1;
				ir.r2.rb     = 6'h3F;
			end
		endcase
		@(negedge clk);
		valid_i = 1'b1;
		ir_i    = ir;
		a_i     = a;
		b_i     = wide_random();
		imm_i   = {{50{ir.ri.imm[13]}}, ir.ri.imm};
		tid_i   = 6'($random(seed));
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			valid_i = 1'b0;
		end
	endtask

	// =========================================================================
	// Test sequence
	// =========================================================================

	initial
	begin
		seed    = 53;
		clk     = 1'b0;
		rst_i   = 1'b1;
		valid_i = 1'b0;
		ir_i    = '0;
		a_i     = '0;
		b_i     = '0;
		imm_i   = '0;
		tid_i   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		// Nothing may come out while the unit sits idle after reset
		idle(SETTLE);
		// Register and immediate multiplies back to back
		for (int n = 0; n < N_MUL; n++)
			issue_op(n % 2, wide_random());
		idle(GAP);
		for (int n = 0; n < 6; n++)
			issue_op(2, I2F_EDGES[n]);
		for (int n = 0; n < N_I2F; n++)
			issue_op(2, operand_for(2));
		idle(GAP);
		// Each directed double goes through both rounding results
		for (int n = 0; n < 8; n++)
		begin
			issue_op(3, FP_EDGES[n]);
			issue_op(4, FP_EDGES[n]);
		end
		for (int n = 0; n < N_FP; n++)
			issue_op(3 + n % 2, operand_for(3));
		idle(GAP);
		for (int n = 0; n < 3; n++)
			issue_op(5, CMP_EDGES[n]);
		for (int n = 0; n < N_CMP; n++)
			issue_op(5, wide_random());
		for (int n = 6; n < 9; n++)
			issue_op(n, wide_random());
		idle(GAP);
		// Full-rate mix of every kind with random tags
		for (int n = 0; n < N_MIX; n++)
		begin
			int kind;
			kind = {$random(seed)} % 9;
			issue_op(kind, operand_for(kind));
		end
		idle(LATENCY + 4);
		if (u_dut.u_chk.fail_seen)
		begin
			$display("error at %0t ns: the run ended with a failed check", $time);
			$display("*** TEST FAILED ***");
			$fatal(1, "Run ended with a failed check");
		end
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- verilog/fp_round_unit.sv
`timescale 1ns/1ps

module fp_round_unit
(
	input  logic                      clk,
	input  mc_alu_pkg::double_value_t d_i,
	output mc_alu_pkg::double_value_t int_o,
	output mc_alu_pkg::double_value_t trunc_o
);
	import mc_alu_pkg::*;

	// =========================================================================
	// Stage one: unpack
	// =========================================================================

	double_value_t      raw1_q;
	logic signed [11:0] uexp1_q;
	logic [52:0]        man1_q;

	always_ff @(posedge clk)
	begin
		raw1_q  <= d_i;
		// Unbiased exponent, denormals land far below zero
		uexp1_q <= $signed({1'b0, d_i[62:52]}) - 12'sd1023;
		// Hidden bit is set for every normal number
		man1_q  <= {d_i[62:52] != 11'd0, d_i[51:0]};
	end

	// =========================================================================
	// Stage two: integer magnitude and fraction mask
	// =========================================================================

	logic [63:0]   mag;
	logic [51:0]   frac_mask;
	double_value_t raw2_q;
	logic [63:0]   mag2_q;
	logic [51:0]   mask2_q;
	logic          small2_q;
	logic          big2_q;

	always_comb
	begin
		mag       = '0;
		frac_mask = '1;
		// Below one the whole value is fraction, mag and mask keep their defaults
		if (uexp1_q >= 12'sd52)
		begin
			// No fractional bits remain, the mantissa moves up
			// Exponents of 64 and more give junk here but are saturated later
			mag       = {11'd0, man1_q} << (uexp1_q[5:0] - 6'd52);
			frac_mask = '0;
		end
		else if (uexp1_q >= 12'sd0)
		begin
			// The low 52 - e mantissa bits sit right of the binary point
			mag       = {11'd0, man1_q} >> (6'd52 - uexp1_q[5:0]);
			frac_mask = {52{1'b1}} >> uexp1_q[5:0];
		end
	end

	always_ff @(posedge clk)
	begin
		raw2_q   <= raw1_q;
		mag2_q   <= mag;
		mask2_q  <= frac_mask;
		small2_q <= uexp1_q < 12'sd0;
		big2_q   <= uexp1_q >= 12'sd63;
	end

	// =========================================================================
	// Stage three: sign, saturation and truncated double
	// =========================================================================

	logic          special;
	double_value_t int_q;
	double_value_t trunc_q;

	// All-ones exponent marks NaN and infinity
	assign special = raw2_q[62:52] == 11'h7FF;

	always_ff @(posedge clk)
	begin
		// Magnitudes of 2^63 and up do not fit, clamp by sign
		// NaN and infinity also fall in here since their exponent is 1024
		if (big2_q)
		begin
			int_q <= raw2_q[63] ? 64'h8000_0000_0000_0000 : 64'h7FFF_FFFF_FFFF_FFFF;
		end
		else
		begin
			int_q <= raw2_q[63] ? (~mag2_q + 64'd1) : mag2_q;
		end

		if (special)
		begin
			trunc_q <= raw2_q;
		end
		else if (small2_q)
		begin
			// Magnitude below one truncates to zero of the same sign
			trunc_q <= {raw2_q[63], 63'd0};
		end
		else
		begin
			trunc_q <= {raw2_q[63:52], raw2_q[51:0] & ~mask2_q};
		end
	end

	assign int_o   = int_q;
	assign trunc_o = trunc_q;

endmodule

//--- verilog/int_to_double.sv
`timescale 1ns/1ps

module int_to_double
(
	input  logic                      clk,
	input  mc_alu_pkg::double_value_t i_i,
	output mc_alu_pkg::double_value_t o_o
);
	import mc_alu_pkg::*;

	// Leading zero count of a 64-bit word, 64 when the word is zero
	function automatic logic [6:0] count_lz(input logic [63:0] v);
		logic [6:0] cnt;
		cnt = 7'd64;
		// The last set bit seen while scanning upward is the highest one
		for (int n = 0; n < 64; n++)
		begin
			if (v[n])
			begin
				cnt = 7'(63 - n);
			end
		end
		return cnt;
	endfunction

	// =========================================================================
	// Stage one: sign, magnitude and leading zero count
	// =========================================================================

	logic [63:0] mag;
	logic        sign_q;
	logic [63:0] mag_q;
	logic [6:0]  lz_q;

	// Two's complement of the most negative value is 2^63, which is still the
	// correct unsigned magnitude
	assign mag = i_i[63] ? (~i_i + 64'd1) : i_i;

	always_ff @(posedge clk)
	begin
		sign_q <= i_i[63];
		mag_q  <= mag;
		lz_q   <= count_lz(mag);
	end

	// =========================================================================
	// Stage two: normalize, truncate and assemble
	// =========================================================================

	logic [63:0]   norm;
	logic [10:0]   exp_field;
	double_value_t result;
	double_value_t o_q;

	always_comb
	begin
		// Shift the leading one up to bit 63, it becomes the hidden bit
		norm      = mag_q << lz_q[5:0];
		// Bias of 1023 plus the 63 bit positions below the leading one
		exp_field = 11'd1086 - {4'd0, lz_q};
		// Bits below the 52 kept mantissa bits are dropped, which truncates
		result    = {sign_q, exp_field, norm[62:11]};
		// A count of 64 means the input was zero, which maps to +0
		if (lz_q[6])
		begin
			result = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		o_q <= result;
	end

	assign o_o = o_q;

endmodule

//--- verilog/mc_alu64.sv
`timescale 1ns/1ps

module mc_alu64 #(
	parameter int ALU_LATENCY = 8
)
(
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      valid_i,
	input  mc_alu_pkg::instruction_t  ir_i,
	input  mc_alu_pkg::double_value_t a_i,
	input  mc_alu_pkg::double_value_t b_i,
	input  mc_alu_pkg::double_value_t imm_i,
	input  mc_alu_pkg::tid_t          tid_i,
	output mc_alu_pkg::double_value_t o_o,
	output logic                      done_o,
	output mc_alu_pkg::tid_t          tid_o
);
	import mc_alu_pkg::*;

	// The multiplier alignment delay needs at least one stage
	if (ALU_LATENCY < MUL_STAGES + 1)
	begin : g_latency_check
		$error("ALU_LATENCY must be at least MUL_STAGES + 1");
	end

	// =========================================================================
	// Decode
	// =========================================================================

	alu_sel_e      sel;
	logic          use_imm;
	double_value_t mcand;

	// MULI uses the immediate view of the word, everything else the register view
	assign use_imm = ir_i.ri.opcode == OP_MULI;
	assign mcand   = use_imm ? imm_i : b_i;

	always_comb
	begin
		sel = SEL_NONE;
		if (use_imm)
		begin
			sel = SEL_MUL;
		end
		else if (ir_i.r2.opcode == OP_R2)
		begin
			case (ir_i.r2.func)
				OP_MUL:
				begin
					sel = SEL_MUL;
				end
				OP_R1:
				begin
					// One-operand group, the sub-code rides in the rb field
					case (r1_e'(ir_i.r2.rb))
						OP_I2F:     sel = SEL_I2F;
						OP_F2I:     sel = SEL_F2I;
						OP_FTRUNC:  sel = SEL_TRUNC;
						OP_MCMPRSS: sel = SEL_CMPRSS;
						default:    sel = SEL_NONE;
					endcase
				end
				default:
				begin
					sel = SEL_NONE;
				end
			endcase
		end
	end

	// =========================================================================
	// Bit compress
	// =========================================================================

	logic [6:0]    ones;
	double_value_t cmprss;

	// Packing the set bits to the bottom only depends on how many there are
	always_comb
	begin
		ones = '0;
		for (int n = 0; n < 64; n++)
		begin
			ones = ones + 7'(a_i[n]);
		end
		// A shift by 64 clears the word, so a full popcount gives all ones
		cmprss = ~(64'hFFFF_FFFF_FFFF_FFFF << ones);
	end

	// =========================================================================
	// Pipes and alignment
	// =========================================================================

	double_value_t mul_p;
	double_value_t mul_r;
	double_value_t i2f_p;
	double_value_t i2f_r;
	double_value_t f2i_p;
	double_value_t f2i_r;
	double_value_t trunc_p;
	double_value_t trunc_r;
	double_value_t cmprss_r;
	logic [2:0]    sel_r;
	logic          valid_r;
	tid_t          tid_r;

	mul64_pipe u_mul
	(
		.clk (clk),
		.a_i (a_i),
		.b_i (mcand),
		.p_o (mul_p)
	);

	// Each pipe output is topped up to the common latency
	tag_delay #(.WID(64), .DEP(ALU_LATENCY - MUL_STAGES)) u_mul_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   (mul_p),
		.q_o   (mul_r)
	);

	int_to_double u_i2f
	(
		.clk (clk),
		.i_i (a_i),
		.o_o (i2f_p)
	);

	tag_delay #(.WID(64), .DEP(ALU_LATENCY - I2F_STAGES)) u_i2f_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   (i2f_p),
		.q_o   (i2f_r)
	);

	fp_round_unit u_fpr
	(
		.clk     (clk),
		.d_i     (a_i),
		.int_o   (f2i_p),
		.trunc_o (trunc_p)
	);

	// Both rounding results share a depth, so they travel side by side
	tag_delay #(.WID(128), .DEP(ALU_LATENCY - FPR_STAGES)) u_fpr_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   ({f2i_p, trunc_p}),
		.q_o   ({f2i_r, trunc_r})
	);

	tag_delay #(.WID(64), .DEP(ALU_LATENCY)) u_cmprss_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   (cmprss),
		.q_o   (cmprss_r)
	);

	// Select and tag follow the instruction through the full latency
	tag_delay #(.WID($bits(alu_sel_e)), .DEP(ALU_LATENCY)) u_sel_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   (sel),
		.q_o   (sel_r)
	);

	tag_delay #(.WID($bits(tid_t)), .DEP(ALU_LATENCY)) u_tid_dly
	(
		.clk   (clk),
		.rst_i (1'b0),
		.d_i   (tid_i),
		.q_o   (tid_r)
	);

	// Only the valid chain is cleared, so no done strobe escapes after reset
	tag_delay #(.WID(1), .DEP(ALU_LATENCY)) u_valid_dly
	(
		.clk   (clk),
		.rst_i (rst_i),
		.d_i   (valid_i),
		.q_o   (valid_r)
	);

	// =========================================================================
	// Result select
	// =========================================================================

	// The mux follows the select that came down with the result, not the
	// instruction currently at the input
	always_comb
	begin
		case (alu_sel_e'(sel_r))
			SEL_MUL:    o_o = mul_r;
			SEL_I2F:    o_o = i2f_r;
			SEL_F2I:    o_o = f2i_r;
			SEL_TRUNC:  o_o = trunc_r;
			SEL_CMPRSS: o_o = cmprss_r;
			default:    o_o = '0;
		endcase
	end

	assign done_o = valid_r;
	assign tid_o  = tid_r;

endmodule

//--- verilog/mc_alu_pkg.sv
package mc_alu_pkg;

	// =========================================================================
	// Instruction encoding
	// =========================================================================

	// Major opcode in the top six bits of every instruction word
	typedef enum logic [5:0]
	{
		OP_R2   = 6'h02,
		OP_MULI = 6'h06
	} opcode_e;

	// Function code of the register format, only meaningful under OP_R2
	typedef enum logic [5:0]
	{
		OP_R1  = 6'h01,
		OP_MUL = 6'h0C
	} func_e;

	// One-operand operations reuse the rb field as a sub-code
	typedef enum logic [5:0]
	{
		OP_I2F     = 6'h10,
		OP_F2I     = 6'h11,
		OP_FTRUNC  = 6'h12,
		OP_MCMPRSS = 6'h20
	} r1_e;

	// The opcode sits in the same six bits of both views, so it can be read
	// through either one before the rest of the word is interpreted
	typedef union packed
	{
		struct packed
		{
			opcode_e     opcode;
			logic [5:0]  rd;
			logic [5:0]  ra;
			logic [5:0]  rb;
			func_e       func;
			logic [1:0]  spare;
		} r2;
		struct packed
		{
			opcode_e     opcode;
			logic [5:0]  rd;
			logic [5:0]  ra;
			logic [13:0] imm;
		} ri;
	} instruction_t;

	// =========================================================================
	// Data and control types
	// =========================================================================

	typedef logic [63:0] double_value_t;
	typedef logic [5:0]  tid_t;

	// Result select carried alongside each instruction to the output mux
	typedef enum logic [2:0]
	{
		SEL_NONE   = 3'd0,
		SEL_MUL    = 3'd1,
		SEL_I2F    = 3'd2,
		SEL_F2I    = 3'd3,
		SEL_TRUNC  = 3'd4,
		SEL_CMPRSS = 3'd5
	} alu_sel_e;

	// Register depth of each free-running pipe
	localparam int MUL_STAGES = 6;
	localparam int I2F_STAGES = 2;
	localparam int FPR_STAGES = 3;

endpackage

//--- verilog/mul64_pipe.sv
`timescale 1ns/1ps

module mul64_pipe
(
	input  logic                      clk,
	input  mc_alu_pkg::double_value_t a_i,
	input  mc_alu_pkg::double_value_t b_i,
	output mc_alu_pkg::double_value_t p_o
);
	import mc_alu_pkg::*;

	// Registers left over after the partial product and sum stages
	localparam int TAIL = MUL_STAGES - 2;

	logic [63:0]                pp_ll_q;
	logic [31:0]                pp_lh_q;
	logic [31:0]                pp_hl_q;
	double_value_t              sum_q;
	double_value_t [TAIL-1:0]   tail_q;

	// Stage one forms the partial products of the 32-bit halves
	// The high by high product lies entirely above bit 63 and is never formed
	// The cross products only reach the low word with their own low 32 bits
	always_ff @(posedge clk)
	begin
		pp_ll_q <= a_i[31:0] * b_i[31:0];
		pp_lh_q <= a_i[31:0] * b_i[63:32];
		pp_hl_q <= a_i[63:32] * b_i[31:0];
	end

	// Stage two adds the cross terms into the upper word
	always_ff @(posedge clk)
	begin
		sum_q <= pp_ll_q + {pp_lh_q + pp_hl_q, 32'd0};
	end

	// The remaining stages only carry the product so the pipe depth matches
	always_ff @(posedge clk)
	begin
		tail_q[0] <= sum_q;
		for (int n = 1; n < TAIL; n++)
		begin
			tail_q[n] <= tail_q[n-1];
		end
	end

	assign p_o = tail_q[TAIL-1];

endmodule

//--- verilog/tag_delay.sv
`timescale 1ns/1ps

module tag_delay #(
	parameter int WID = 1,
	parameter int DEP = 1
)
(
	input  logic           clk,
	input  logic           rst_i,
	input  logic [WID-1:0] d_i,
	output logic [WID-1:0] q_o
);

	// Stage 0 takes the input, the last stage drives the output
	logic [DEP-1:0][WID-1:0] stage_q;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			stage_q <= '0;
		end
		else
		begin
			stage_q[0] <= d_i;
			// Each stage copies its neighbour, giving exactly DEP cycles of delay
			for (int n = 1; n < DEP; n++)
			begin
				stage_q[n] <= stage_q[n-1];
			end
		end
	end

	assign q_o = stage_q[DEP-1];

endmodule

//--- vlog.f
verilog/mc_alu_pkg.sv
verilog/tag_delay.sv
verilog/mul64_pipe.sv
verilog/int_to_double.sv
verilog/fp_round_unit.sv
verilog/mc_alu64.sv
verification/mc_alu_checker.sv
verification/mc_alu_tb.sv
